//--- src.f
+incdir+rtl
rtl/ntm_fixed_pkg.sv
rtl/ntm_ctrl_pkg.sv
rtl/ntm_scalar_exponentiator.sv
rtl/ntm_vector_exponentiator_function.sv
rtl/ntm_matrix_exponentiator_function.sv
dv/ntm_exponentiator_props.sv
dv/ntm_exponentiator_tb.sv

//--- Bender.yml
package:
  name: ntm_exponentiator

export_include_dirs:
  - rtl

sources:
  # RTL, packages first
  - include_dirs:
      - rtl
    files:
      - rtl/ntm_fixed_pkg.sv
      - rtl/ntm_ctrl_pkg.sv
      - rtl/ntm_scalar_exponentiator.sv
      - rtl/ntm_vector_exponentiator_function.sv
      - rtl/ntm_matrix_exponentiator_function.sv
  # Testbench and bound properties
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/ntm_exponentiator_props.sv
      - dv/ntm_exponentiator_tb.sv

//--- dv/ntm_exponentiator_tb.sv
////////////////////////////////////////
// NTM matrix exponentiator testbench
// LCG stimulus, bit-exact e^x model,
// in-order result and flag checking
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_exponentiator_tb
  import ntm_fixed_pkg::*;
();

  localparam int     DRAIN_TIMEOUT = 100;
  localparam longint WORD_MAX      = 64'sh7fff_ffff;
  localparam longint WORD_MIN      = -64'sh8000_0000;

  logic   CLK;
  logic   RST;
  logic   START;
  fixed_t SIZE_I_IN;
  fixed_t SIZE_J_IN;
  logic   DATA_IN_I_ENABLE;
  logic   DATA_IN_J_ENABLE;
  fixed_t DATA_IN;
  logic   READY;
  logic   DATA_OUT_ENABLE;
  logic   DATA_OUT_I_ENABLE;
  fixed_t DATA_OUT;

  // Expected entries are {last, first, value}
  logic [33:0] exp_q[$];
  logic [33:0] exp_entry;
  fixed_t      data_q[$];
  fixed_t      saved_q[$];
  int          rows_a[8];
  int          cols_a[8];

  logic [31:0] seed;
  int errors;
  int checks;
  int test_errors;
  int rows_sent;
  int matrices_started;
  int i_count;
  int ready_count;
  int k;
  int n;

  ntm_matrix_exponentiator_function UUT (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .SIZE_I_IN        (SIZE_I_IN),
    .SIZE_J_IN        (SIZE_J_IN),
    .DATA_IN_I_ENABLE (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE (DATA_IN_J_ENABLE),
    .DATA_IN          (DATA_IN),
    .READY            (READY),
    .DATA_OUT_ENABLE  (DATA_OUT_ENABLE),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
    .DATA_OUT         (DATA_OUT)
  );

  bind ntm_matrix_exponentiator_function ntm_exponentiator_props output_props (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .READY            (READY),
    .DATA_OUT_ENABLE  (DATA_OUT_ENABLE),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE)
  );

  // 8 ns clock
  always #4 CLK = ~CLK;

  ////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // e^x as 2^(x*log2e) with floored products, clamping and saturation
  function automatic fixed_t exp_model(input fixed_t x);
    longint  scaled;
    longint  ip;
    longint  f;
    longint  coef;
    longint  pow;
    scaled_u w;
    fixed_t  p32;
    scaled = (longint'(x) * `NTM_LOG2E) >>> `NTM_FRAC_SIZE;
    if (scaled > WORD_MAX) scaled = WORD_MAX;
    if (scaled < WORD_MIN) scaled = WORD_MIN;
    w.raw = scaled[31:0];
    ip    = w.parts.int_part;
    f     = w.parts.frac;
    coef  = `NTM_POLY_C1 + ((f * `NTM_POLY_C2) >>> `NTM_FRAC_SIZE);
    pow   = (64'sd1 <<< `NTM_FRAC_SIZE) + ((f * coef) >>> `NTM_FRAC_SIZE);
    p32   = pow[31:0];
    if (ip > `NTM_EXP_INT_MAX) return 32'sh7fff_ffff;
    if (ip < `NTM_EXP_INT_MIN) return '0;
    if (ip >= 0) return p32 <<< ip;
    return p32 >>> (-ip);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic check_idle();
    check_value("READY", READY, 0);
    check_value("DATA_OUT_ENABLE", DATA_OUT_ENABLE, 0);
    check_value("DATA_OUT_I_ENABLE", DATA_OUT_I_ENABLE, 0);
    check_value("DATA_OUT", DATA_OUT, 0);
  endtask

  // Bounded wait until every expected result has been seen
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() > 0 && cycles < DRAIN_TIMEOUT) begin
      @(posedge CLK);
      #1;
      cycles++;
    end
    if (exp_q.size() > 0) begin
      $display("Timeout: %0d results still missing after %0d cycles", exp_q.size(), cycles);
      $display(">>> FAIL");
      $finish;
    end
  endtask

  // Starts 1 ns after a rising edge and takes values from data_q
  task automatic send_matrix(input int rows, input int cols, input int max_gap);
    int     r;
    int     c;
    int     gap;
    fixed_t val;
    START     = 1'b1;
    SIZE_I_IN = rows;
    SIZE_J_IN = cols;
    @(posedge CLK);
    #1;
    START = 1'b0;
    matrices_started++;
    rows_sent += rows;
    for (r = 0; r < rows; r++) begin
      for (c = 0; c < cols; c++) begin
        val              = data_q.pop_front();
        DATA_IN          = val;
        DATA_IN_I_ENABLE = (c == 0);
        DATA_IN_J_ENABLE = (c != 0);
        exp_q.push_back({(r == rows - 1) && (c == cols - 1), c == 0, exp_model(val)});
        @(posedge CLK);
        #1;
        DATA_IN_I_ENABLE = 1'b0;
        DATA_IN_J_ENABLE = 1'b0;
        seed = lcg_step(seed);
        gap  = seed[31:16] % (max_gap + 1);
        repeat (gap) begin
          @(posedge CLK);
          #1;
        end
      end
    end
    wait_drain();
  endtask

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST && DATA_OUT_ENABLE) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected result %h with nothing left to expect", DATA_OUT);
      end else begin
        exp_entry = exp_q.pop_front();
        check_value("DATA_OUT", DATA_OUT, exp_entry[31:0]);
        check_value("DATA_OUT_I_ENABLE", DATA_OUT_I_ENABLE, exp_entry[32]);
        check_value("READY", READY, exp_entry[33]);
      end
    end
    if (!RST && DATA_OUT_I_ENABLE) i_count++;
    if (!RST && READY) ready_count++;
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial begin
    CLK              = 1'b0;
    RST              = 1'b0;
    START            = 1'b0;
    SIZE_I_IN        = '0;
    SIZE_J_IN        = '0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    DATA_IN          = '0;
    seed             = 32'h8f6;
    errors           = 0;
    checks           = 0;
    rows_sent        = 0;
    matrices_started = 0;
    i_count          = 0;
    ready_count      = 0;

    // Reset rises just after time zero
    #1;
    RST = 1'b1;

    // Test 1 checks idle outputs in and after reset
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    check_idle();
    repeat (12) @(posedge CLK);
    #1;
    RST = 1'b0;
    @(negedge CLK);
    check_idle();
    @(posedge CLK);
    #1;
    $display("Test 1 reset state: %0d errors", errors);

    // Test 2 sends single elements 0, 1.0 and -1.0
    test_errors = errors;
    data_q = '{32'sh0000_0000, 32'sh0001_0000, 32'shffff_0000};
    repeat (3) send_matrix(1, 1, 0);
    $display("Test 2 one by one: %0d errors", errors - test_errors);

    // Test 3 uses random sizes with back to back elements
    test_errors = errors;
    for (k = 0; k < 8; k++) begin
      seed = lcg_step(seed);
      rows_a[k] = 1 + seed[31:16] % 6;
      seed = lcg_step(seed);
      cols_a[k] = 1 + seed[31:16] % 6;
      for (n = 0; n < rows_a[k] * cols_a[k]; n++) begin
        // About -16.0 to +16.0
        seed = lcg_step(seed);
        data_q.push_back($signed(seed) >>> 11);
        saved_q.push_back(data_q[$]);
      end
      send_matrix(rows_a[k], cols_a[k], 0);
    end
    $display("Test 3 random back to back: %0d errors", errors - test_errors);

    // Test 4 repeats the matrices with gaps of up to 5 cycles
    test_errors = errors;
    data_q = saved_q;
    for (k = 0; k < 8; k++) begin
      send_matrix(rows_a[k], cols_a[k], 5);
    end
    $display("Test 4 random with gaps: %0d errors", errors - test_errors);

    // Test 5 probes around and beyond the exponent limits
    test_errors = errors;
    data_q = '{32'sh000a_0000, 32'sh000a_8000, 32'sh7fff_ffff,
               32'shfff5_0000, 32'shfff4_8000, 32'sh8000_0000};
    send_matrix(1, 6, 1);
    $display("Test 5 saturation limits: %0d errors", errors - test_errors);

    // Test 6 compares strobe counts over the whole run
    test_errors = errors;
    check_value("DATA_OUT_I_ENABLE count", i_count, rows_sent);
    check_value("READY count", ready_count, matrices_started);
    $display("Test 6 strobe counts: %0d errors", errors - test_errors);

    // Bound assertion failures count against the run
    check_value("output_props.fail_count", UUT.output_props.fail_count, 0);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/ntm_exponentiator_props.sv
////////////////////////////////////////
// NTM matrix exponentiator properties
// Output strobe rules at the top level
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ntm_exponentiator_props (
  input wire CLK,
  input wire RST,
  input wire START,
  input wire READY,
  input wire DATA_OUT_ENABLE,
  input wire DATA_OUT_I_ENABLE
);

  // Set by READY, cleared by the next START
  logic done_seen;

  // Number of failed assertions
  int fail_count = 0;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      done_seen <= 1'b0;
    end else if (START) begin
      done_seen <= 1'b0;
    end else if (READY) begin
      done_seen <= 1'b1;
    end
  end

  // Markers only ride on a result
  ready_has_data: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE)
    else begin
      fail_count++;
      $error("READY without DATA_OUT_ENABLE");
    end

  row_mark_has_data: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_I_ENABLE |-> DATA_OUT_ENABLE)
    else begin
      fail_count++;
      $error("DATA_OUT_I_ENABLE without DATA_OUT_ENABLE");
    end

  quiet_in_reset: assert property (@(posedge CLK)
    RST |-> !(READY || DATA_OUT_ENABLE || DATA_OUT_I_ENABLE))
    else begin
      fail_count++;
      $error("Output strobe high during reset");
    end

  // No result after a finished matrix until a new START
  quiet_after_ready: assert property (@(posedge CLK) disable iff (RST)
    done_seen |-> !DATA_OUT_ENABLE)
    else begin
      fail_count++;
      $error("DATA_OUT_ENABLE after READY before a new START");
    end

endmodule

`default_nettype wire

//--- rtl/ntm_matrix_exponentiator_function.sv
////////////////////////////////////////
// NTM matrix exponentiator, top level
// Element-wise e^x of an I x J matrix,
// rows go one after another through
// the vector block
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_matrix_exponentiator_function
  import ntm_fixed_pkg::*, ntm_ctrl_pkg::*;
(
  input  wire    CLK,
  input  wire    RST,
  input  wire    START,
  input  fixed_t SIZE_I_IN,
  input  fixed_t SIZE_J_IN,
  input  wire    DATA_IN_I_ENABLE,
  input  wire    DATA_IN_J_ENABLE,
  input  fixed_t DATA_IN,
  output logic   READY,
  output logic   DATA_OUT_ENABLE,
  output logic   DATA_OUT_I_ENABLE,
  output fixed_t DATA_OUT
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  matrix_state_e state;

  // Matrix size, latched on START
  fixed_t size_i_q;
  fixed_t size_j_q;

  // Input side, rows issued and column within the row
  logic [`NTM_DATA_SIZE-1:0] rows_in;
  logic [`NTM_DATA_SIZE-1:0] col;
  logic [`NTM_DATA_SIZE-1:0] col_cur;
  logic                      accept_i;
  logic                      accept_j;
  logic                      elem_accept;
  logic                      row_done;

  // Output side, rows completed and row-start marker
  logic [`NTM_DATA_SIZE-1:0] rows_out;
  logic                      row_first;

  // Vector block results
  logic   v_ready;
  logic   v_out_en;
  fixed_t v_out;

  ////////////////////////////////////////
  // Input sequencing
  ////////////////////////////////////////

  // I strobe opens a row, J strobes fill it
  assign accept_i    = DATA_IN_I_ENABLE && (state == MAT_ROW_START);
  assign accept_j    = DATA_IN_J_ENABLE && (state == MAT_ROW_BODY);
  assign elem_accept = accept_i || accept_j;
  assign col_cur     = accept_i ? '0 : col;
  assign row_done    = (col_cur + 32'd1) == size_j_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= MAT_IDLE;
      size_i_q <= '0;
      size_j_q <= '0;
      rows_in  <= '0;
      col      <= '0;
    end else if (state == MAT_IDLE) begin
      if (START) begin
        size_i_q <= SIZE_I_IN;
        size_j_q <= SIZE_J_IN;
        rows_in  <= '0;
        col      <= '0;
        state    <= MAT_ROW_START;
      end
    end else if (elem_accept) begin
      if (row_done) begin
        col <= '0;
        // Last element of the last row ends the input side
        if ((rows_in + 32'd1) == size_i_q) begin
          state <= MAT_IDLE;
        end else begin
          rows_in <= rows_in + 32'd1;
          state   <= MAT_ROW_START;
        end
      end else begin
        col   <= col_cur + 32'd1;
        state <= MAT_ROW_BODY;
      end
    end
  end

  ////////////////////////////////////////
  // Vector block
  ////////////////////////////////////////

  ntm_vector_exponentiator_function vector_exponentiator_function (
    .CLK            (CLK),
    .RST            (RST),
    .START          (accept_i),
    .SIZE_IN        (size_j_q),
    .DATA_IN_ENABLE (elem_accept),
    .DATA_IN        (DATA_IN),
    .READY          (v_ready),
    .DATA_OUT_ENABLE(v_out_en),
    .DATA_OUT       (v_out)
  );

  ////////////////////////////////////////
  // Registered outputs
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY             <= 1'b0;
      DATA_OUT_ENABLE   <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT          <= '0;
      rows_out          <= '0;
      row_first         <= 1'b1;
    end else begin
      DATA_OUT_ENABLE   <= v_out_en;
      DATA_OUT_I_ENABLE <= v_out_en && row_first;
      // Matrix done on the READY of the last row
      READY             <= v_ready && ((rows_out + 32'd1) == size_i_q);
      if (v_out_en) begin
        DATA_OUT <= v_out;
      end

      // Next result after a row end opens a new row
      if (v_ready) begin
        rows_out  <= rows_out + 32'd1;
        row_first <= 1'b1;
      end else if (v_out_en) begin
        row_first <= 1'b0;
      end

      // New matrix restarts the row count
      if (START && (state == MAT_IDLE)) begin
        rows_out  <= '0;
        row_first <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/ntm_vector_exponentiator_function.sv
////////////////////////////////////////
// NTM vector exponentiator
// Streams one row through the scalar
// pipeline, READY marks the last result
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_vector_exponentiator_function
  import ntm_fixed_pkg::*, ntm_ctrl_pkg::*;
(
  input  wire    CLK,
  input  wire    RST,
  input  wire    START,
  input  fixed_t SIZE_IN,
  input  wire    DATA_IN_ENABLE,
  input  fixed_t DATA_IN,
  output logic   READY,
  output logic   DATA_OUT_ENABLE,
  output fixed_t DATA_OUT
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  vector_state_e state;

  // Row length and elements issued so far
  fixed_t                    size_q;
  logic [`NTM_DATA_SIZE-1:0] count;

  // Element acceptance
  fixed_t                    cur_size;
  logic [`NTM_DATA_SIZE-1:0] cur_count;
  logic                      accept;
  logic                      is_last;

  // Registered input
  logic   en_r;
  logic   last_r;
  fixed_t data_r;

  // Last-element tag, runs beside the scalar stages
  logic [`NTM_SCALAR_LATENCY-1:0] tag;

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  // START comes with the first element
  assign cur_size  = (state == VEC_IDLE) ? SIZE_IN : size_q;
  assign cur_count = (state == VEC_IDLE) ? '0 : count;
  assign accept    = DATA_IN_ENABLE && ((state == VEC_STREAM) || START);
  assign is_last   = (cur_count + 32'd1) == cur_size;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= VEC_IDLE;
      size_q <= '0;
      count  <= '0;
      en_r   <= 1'b0;
      last_r <= 1'b0;
      tag    <= '0;
    end else begin
      en_r   <= accept;
      last_r <= accept && is_last;
      tag    <= {tag[`NTM_SCALAR_LATENCY-2:0], last_r};

      case (state)
        VEC_IDLE: begin
          if (START) begin
            size_q <= SIZE_IN;
            state  <= VEC_STREAM;
          end
        end
        VEC_STREAM: begin
          // Stays here until the row is issued
        end
      endcase

      // Count issued elements, back to idle on the last
      if (accept) begin
        if (is_last) begin
          count <= '0;
          state <= VEC_IDLE;
        end else begin
          count <= cur_count + 32'd1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      data_r <= DATA_IN;
    end
  end

  ////////////////////////////////////////
  // Scalar pipeline
  ////////////////////////////////////////

  ntm_scalar_exponentiator scalar_exponentiator (
    .CLK            (CLK),
    .RST            (RST),
    .DATA_IN_ENABLE (en_r),
    .DATA_IN        (data_r),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .DATA_OUT       (DATA_OUT)
  );

  // Tag lines up with its own result
  assign READY = DATA_OUT_ENABLE && tag[`NTM_SCALAR_LATENCY-1];

endmodule

`default_nettype wire

//--- rtl/ntm_scalar_exponentiator.sv
////////////////////////////////////////
// NTM scalar exponentiator
// Four-stage e^x in signed Q16.16
// e^x = 2^(x*log2e), 2^f by polynomial,
// integer part applied as a shift
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_scalar_exponentiator
  import ntm_fixed_pkg::*;
(
  input  wire    CLK,
  input  wire    RST,
  input  wire    DATA_IN_ENABLE,
  input  fixed_t DATA_IN,
  output logic   DATA_OUT_ENABLE,
  output fixed_t DATA_OUT
);

  localparam int IW = `NTM_DATA_SIZE - `NTM_FRAC_SIZE;

  // Constants widened for the products
  localparam logic signed [2*`NTM_DATA_SIZE-1:0] LOG2E_W = `NTM_LOG2E;
  localparam logic signed [2*`NTM_DATA_SIZE-1:0] C2_W    = `NTM_POLY_C2;
  localparam fixed_t C1      = `NTM_POLY_C1;
  localparam fixed_t FIX_ONE = 32'sd1 <<< `NTM_FRAC_SIZE;
  localparam fixed_t SAT_MAX = 32'sh7fff_ffff;

  // Clamp bounds for the scaled word
  localparam logic signed [2*`NTM_DATA_SIZE-1:0] RAW_MAX = 64'sh7fff_ffff;
  localparam logic signed [2*`NTM_DATA_SIZE-1:0] RAW_MIN = -64'sh8000_0000;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Valid bits, one per stage
  logic v1, v2, v3;

  // Stage 1
  logic signed [2*`NTM_DATA_SIZE-1:0] prod_scale;
  logic signed [2*`NTM_DATA_SIZE-1:0] scaled_full;
  fixed_t                             scaled_sat;
  scaled_u                            s1_word;

  // Stage 2
  logic signed [2*`NTM_DATA_SIZE-1:0] prod_inner;
  logic signed [IW-1:0]               s2_int;
  logic [`NTM_FRAC_SIZE-1:0]          s2_frac;
  fixed_t                             s2_coef;

  // Stage 3
  logic signed [2*`NTM_DATA_SIZE-1:0] prod_outer;
  logic signed [IW-1:0]               s3_int;
  fixed_t                             s3_pow;

  // Stage 4
  fixed_t exp_next;

  ////////////////////////////////////////
  // Datapath arithmetic
  ////////////////////////////////////////

  // x * log2(e), floor back to Q16.16
  assign prod_scale  = DATA_IN * LOG2E_W;
  assign scaled_full = prod_scale >>> `NTM_FRAC_SIZE;

  // Keep huge inputs from wrapping the exponent
  always_comb begin
    if (scaled_full > RAW_MAX) begin
      scaled_sat = SAT_MAX;
    end else if (scaled_full < RAW_MIN) begin
      scaled_sat = RAW_MIN[`NTM_DATA_SIZE-1:0];
    end else begin
      scaled_sat = scaled_full[`NTM_DATA_SIZE-1:0];
    end
  end

  // Inner term C2*f, f is unsigned Q0.16
  assign prod_inner = C2_W * $signed({{(2*`NTM_DATA_SIZE-`NTM_FRAC_SIZE){1'b0}},
                                      s1_word.parts.frac});

  // Outer term f*(C1 + C2*f)
  assign prod_outer = $signed({{(2*`NTM_DATA_SIZE-`NTM_FRAC_SIZE){1'b0}}, s2_frac})
                      * s2_coef;

  // 2^int * 2^f, with saturation and flush
  always_comb begin
    if (s3_int > `NTM_EXP_INT_MAX) begin
      exp_next = SAT_MAX;
    end else if (s3_int < `NTM_EXP_INT_MIN) begin
      exp_next = '0;
    end else if (s3_int >= 0) begin
      exp_next = s3_pow <<< s3_int[4:0];
    end else begin
      // At most 16 places, 2^f >= 1 keeps one LSB
      exp_next = s3_pow >>> 5'(-s3_int);
    end
  end

  ////////////////////////////////////////
  // Pipeline registers
  ////////////////////////////////////////

  // Valid chain and result
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      v1              <= 1'b0;
      v2              <= 1'b0;
      v3              <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      v1              <= DATA_IN_ENABLE;
      v2              <= v1;
      v3              <= v2;
      DATA_OUT_ENABLE <= v3;
      if (v3) begin
        DATA_OUT <= exp_next;
      end
    end
  end

  // Stage payloads
  always_ff @(posedge CLK) begin
    s1_word.raw <= scaled_sat;
    // Parts view of the scaled word
    s2_int      <= s1_word.parts.int_part;
    s2_frac     <= s1_word.parts.frac;
    s2_coef     <= C1 + prod_inner[`NTM_FRAC_SIZE +: `NTM_DATA_SIZE];
    s3_int      <= s2_int;
    s3_pow      <= FIX_ONE + prod_outer[`NTM_FRAC_SIZE +: `NTM_DATA_SIZE];
  end

endmodule

`default_nettype wire

//--- rtl/ntm_ctrl_pkg.sv
////////////////////////////////////////
// NTM sequencer state encodings
// Vector row streamer and matrix walker
////////////////////////////////////////

`default_nettype none

package ntm_ctrl_pkg;

  // Vector sequencer
  // Waiting for START, then issuing a row
  typedef enum logic {
    VEC_IDLE,
    VEC_STREAM
  } vector_state_e;

  // Matrix sequencer
  // Row start waits for the I strobe, body takes J strobes
  typedef enum logic [1:0] {
    MAT_IDLE,
    MAT_ROW_START,
    MAT_ROW_BODY
  } matrix_state_e;

endpackage

`default_nettype wire

//--- rtl/ntm_fixed_pkg.sv
////////////////////////////////////////
// NTM number formats
// Signed Q16.16 word and the scaled word
// seen as raw bits or as int/frac parts
////////////////////////////////////////

`default_nettype none

`include "ntm_macros.svh"

package ntm_fixed_pkg;

  ////////////////////////////////////////
  // Plain fixed-point word
  ////////////////////////////////////////

  // Signed Q16.16
  typedef logic signed [`NTM_DATA_SIZE-1:0] fixed_t;

  ////////////////////////////////////////
  // Scaled word, x * log2(e)
  ////////////////////////////////////////

  // Written as one signed word, read back as
  // integer exponent and fractional exponent
  typedef union packed {
    logic signed [`NTM_DATA_SIZE-1:0] raw;
    struct packed {
      logic signed [`NTM_DATA_SIZE-`NTM_FRAC_SIZE-1:0] int_part;
      logic        [`NTM_FRAC_SIZE-1:0]                frac;
    } parts;
  } scaled_u;

endpackage

`default_nettype wire

//--- rtl/ntm_macros.svh
////////////////////////////////////////
// NTM fixed-point exponential constants
// Word format, log2(e) scale factor,
// 2^f polynomial and saturation limits
////////////////////////////////////////

`ifndef NTM_MACROS_SVH
`define NTM_MACROS_SVH

// Word format, signed Q16.16
`define NTM_DATA_SIZE 32
`define NTM_FRAC_SIZE 16

// log2(e) in Q16.16
`define NTM_LOG2E 94548

// 2^f ~ 1 + f*(C1 + f*C2), f in [0,1)
`define NTM_POLY_C1 45426
`define NTM_POLY_C2 15837

// Integer part limits after scaling
`define NTM_EXP_INT_MAX 14
`define NTM_EXP_INT_MIN (-16)

// Scalar pipeline depth in cycles
`define NTM_SCALAR_LATENCY 4

`endif
